/* bench/mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_model #(
   parameter int MEM_WORDS = 4096
) (
   input  wire                         clk,
   input  wire                         reset,
   input  wire                         stall_writes,  // holds aw_ready low
   input  cache_pkg::addr_t            ar_addr,
   input  wire [7:0]                   ar_len,
   input  wire                         ar_valid,
   output logic                        ar_ready,
   output cache_pkg::word_t            r_data,
   output logic                        r_valid,
   output logic                        r_last,
   input  wire                         r_ready,
   input  cache_pkg::addr_t            aw_addr,
   input  cache_pkg::word_t            w_data,
   input  cache_pkg::strb_t            w_strb,
   input  wire                         aw_valid,
   output logic                        aw_ready,
   output logic                        b_valid,
   input  wire                         b_ready,
   output logic                        wr_seen,  // one cycle per accepted write
   output cache_pkg::wr_entry_t        wr_rec
);
   cache_pkg::word_t  words [MEM_WORDS];  // loaded by the testbench
   cache_pkg::addr_t  rd_addr;
   logic [8:0]        rd_left;  // beats still to send

   //////////////////////////////////////////////////
   // read burst
   //////////////////////////////////////////////////

   always @(posedge clk)
   begin
      if (reset)
      begin
         ar_ready <= 1'b0;
         r_valid  <= 1'b0;
         r_last   <= 1'b0;
         rd_left  <= '0;
      end
      else
      begin
         ar_ready <= 1'b0;
         r_valid  <= 1'b0;
         r_last   <= 1'b0;
         if (ar_valid && ar_ready)
         begin
            rd_addr <= ar_addr;
            rd_left <= {1'b0, ar_len} + 9'd1;
         end
         else if (ar_valid && rd_left == 9'd0)
            ar_ready <= 1'b1;  // one cycle late on purpose
         else if (rd_left != 9'd0 && r_ready)
         begin
            r_valid <= 1'b1;
            r_data  <= words[rd_addr[13:2]];
            r_last  <= (rd_left == 9'd1);
            rd_addr <= rd_addr + 32'd4;  // incrementing burst
            rd_left <= rd_left - 9'd1;
         end
      end
   end

   //////////////////////////////////////////////////
   // write and response
   //////////////////////////////////////////////////

   always @(posedge clk)
   begin
      if (reset)
      begin
         aw_ready <= 1'b0;
         b_valid  <= 1'b0;
         wr_seen  <= 1'b0;
      end
      else
      begin
         aw_ready <= 1'b0;
         wr_seen  <= 1'b0;
         if (aw_valid && aw_ready)
         begin
            for (int b = 0; b < cache_pkg::STRB_W; b++)
            begin
               if (w_strb[b])
                  words[aw_addr[13:2]][b*8 +: 8] <= w_data[b*8 +: 8];
            end
            wr_rec.addr <= aw_addr;
            wr_rec.data <= w_data;
            wr_rec.strb <= w_strb;
            wr_seen     <= 1'b1;
            b_valid     <= 1'b1;
         end
         else if (aw_valid && !b_valid && !stall_writes)
            aw_ready <= 1'b1;
         if (b_valid && b_ready)
            b_valid <= 1'b0;  // response taken
      end
   end
endmodule

`default_nettype wire

/* bench/memory_cache_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_cache_assert (
   input wire               clk,
   input wire               reset,
   input wire               cpu_ready,
   input cache_pkg::addr_t  ar_addr,
   input wire               ar_valid,
   input wire               ar_ready,
   input cache_pkg::addr_t  aw_addr,
   input cache_pkg::word_t  w_data,
   input cache_pkg::strb_t  w_strb,
   input wire               aw_valid,
   input wire               aw_ready
);
   // read address held until taken
   ar_hold: assert property (@(posedge clk) disable iff (reset)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
      else $error("ar_valid or ar_addr changed before ar_ready");

   // write address and data held until taken
   aw_hold: assert property (@(posedge clk) disable iff (reset)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(w_data)
                                && $stable(w_strb))
      else $error("aw channel changed before aw_ready");

   ready_pulse: assert property (@(posedge clk) disable iff (reset)
      cpu_ready |=> !cpu_ready)
      else $error("cpu_ready high for two cycles");

   // refill only once the buffer is drained
   ar_after_aw: assert property (@(posedge clk) disable iff (reset)
      $rose(ar_valid) |-> !aw_valid)
      else $error("ar_valid rose while aw_valid high");
endmodule

bind memory_cache memory_cache_assert u_assert (
   .clk(clk), .reset(reset), .cpu_ready(cpu_ready),
   .ar_addr(ar_addr), .ar_valid(ar_valid), .ar_ready(ar_ready),
   .aw_addr(aw_addr), .w_data(w_data), .w_strb(w_strb),
   .aw_valid(aw_valid), .aw_ready(aw_ready)
);

`default_nettype wire

/* bench/memory_cache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_cache_tb;
   localparam int MEM_WORDS      = 4096;
   localparam int BUF_DEPTH      = 4;
   localparam int HIT_CYCLES     = 4;  // sample edge, lookup, compare, ready seen
   localparam int TIMEOUT_CYCLES = 3000;

   logic clk;
   logic reset;
   logic stall_writes;
   logic cpu_valid;
   cache_pkg::addr_t cpu_addr;
   cache_pkg::word_t cpu_wdata;
   cache_pkg::strb_t cpu_wstrb;
   logic cpu_ready;
   cache_pkg::word_t cpu_rdata;
   cache_pkg::addr_t ar_addr;
   logic [7:0] ar_len;
   logic ar_valid, ar_ready, r_valid, r_last, r_ready;
   cache_pkg::word_t r_data;
   cache_pkg::addr_t aw_addr;
   cache_pkg::word_t w_data;
   cache_pkg::strb_t w_strb;
   logic aw_valid, aw_ready, b_valid, b_ready;
   logic wr_seen;
   cache_pkg::wr_entry_t wr_rec;

   cache_pkg::word_t ref_mem [MEM_WORDS];  // expected memory contents
   cache_pkg::wr_entry_t wr_q [$];  // writes seen by memory, in order
   int cycle_count;
   int ar_count;
   int wr_total;
   int writes_at_ar;  // write count at the last refill address
   cache_pkg::addr_t last_ar_addr;
   logic [7:0] last_ar_len;

   memory_cache #(.INDEX_W(6), .WSEL_W(2), .BUF_DEPTH(BUF_DEPTH)) UUT (
      .clk(clk), .reset(reset),
      .cpu_valid(cpu_valid), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
      .cpu_wstrb(cpu_wstrb), .cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata),
      .ar_addr(ar_addr), .ar_len(ar_len), .ar_valid(ar_valid), .ar_ready(ar_ready),
      .r_data(r_data), .r_valid(r_valid), .r_last(r_last), .r_ready(r_ready),
      .aw_addr(aw_addr), .w_data(w_data), .w_strb(w_strb),
      .aw_valid(aw_valid), .aw_ready(aw_ready), .b_valid(b_valid), .b_ready(b_ready)
   );

   mem_model #(.MEM_WORDS(MEM_WORDS)) mem_i (
      .clk(clk), .reset(reset), .stall_writes(stall_writes),
      .ar_addr(ar_addr), .ar_len(ar_len), .ar_valid(ar_valid), .ar_ready(ar_ready),
      .r_data(r_data), .r_valid(r_valid), .r_last(r_last), .r_ready(r_ready),
      .aw_addr(aw_addr), .w_data(w_data), .w_strb(w_strb),
      .aw_valid(aw_valid), .aw_ready(aw_ready), .b_valid(b_valid), .b_ready(b_ready),
      .wr_seen(wr_seen), .wr_rec(wr_rec)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;  // 100 ns period
   end

   //////////////////////////////////////////////////
   // monitors and watchdog
   //////////////////////////////////////////////////

   always @(posedge clk)
   begin
      cycle_count++;
      if (ar_valid && ar_ready)
      begin
         ar_count++;
         last_ar_addr = ar_addr;
         last_ar_len  = ar_len;
         writes_at_ar = wr_total;
      end
      if (wr_seen)
      begin
         wr_q.push_back(wr_rec);
         wr_total++;
      end
      if (cycle_count > TIMEOUT_CYCLES)
         stop_run("timeout, the run took more cycles than the limit");
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   //////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////

   task automatic compare_word(input string name, input cache_pkg::word_t exp,
                               input cache_pkg::word_t act);
      if (exp !== act)
      begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         stop_run("word compare failed");
      end
   endtask

   task automatic compare_addr(input string name, input cache_pkg::addr_t exp,
                               input cache_pkg::addr_t act);
      if (exp !== act)
      begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         stop_run("address compare failed");
      end
   endtask

   task automatic compare_count(input string name, input int exp, input int act);
      if (exp != act)
      begin
         $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
         stop_run("count compare failed");
      end
   endtask

   // waits for the next write that memory took
   task automatic compare_write(input string name, input cache_pkg::wr_entry_t exp);
      cache_pkg::wr_entry_t act;
      while (wr_q.size() == 0)
         @(posedge clk);
      act = wr_q.pop_front();
      if (act !== exp)
      begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         stop_run("write compare failed");
      end
   endtask

   //////////////////////////////////////////////////
   // cpu side
   //////////////////////////////////////////////////

   function automatic cache_pkg::word_t merge(input cache_pkg::word_t old,
                                              input cache_pkg::word_t data,
                                              input cache_pkg::strb_t strb);
      cache_pkg::word_t res;
      res = old;
      for (int b = 0; b < cache_pkg::STRB_W; b++)
      begin
         if (strb[b])
            res[b*8 +: 8] = data[b*8 +: 8];
      end
      return res;
   endfunction

   task automatic cpu_access(input cache_pkg::addr_t addr, input cache_pkg::word_t data,
                             input cache_pkg::strb_t strb, output int cycles);
      @(posedge clk);
      cpu_valid <= 1'b1;
      cpu_addr  <= addr;
      cpu_wdata <= data;
      cpu_wstrb <= strb;
      cycles = 0;
      do
      begin
         @(posedge clk);
         cycles++;
      end
      while (!cpu_ready);
      cpu_valid <= 1'b0;
   endtask

   task automatic cpu_read(input cache_pkg::addr_t addr, output cache_pkg::word_t data,
                           output int cycles);
      cpu_access(addr, '0, 4'b0000, cycles);
      data = cpu_rdata;  // valid in the ready cycle
   endtask

   // posts the write and updates the reference
   task automatic cpu_write(input cache_pkg::addr_t addr, input cache_pkg::word_t data,
                            input cache_pkg::strb_t strb, output int cycles,
                            output cache_pkg::wr_entry_t ent);
      cpu_access(addr, data, strb, cycles);
      ref_mem[addr[13:2]] = merge(ref_mem[addr[13:2]], data, strb);
      ent.addr = {addr[31:2], 2'b00};
      ent.data = data;
      ent.strb = strb;
   endtask

   //////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////

   task automatic test_miss_then_hit();
      cache_pkg::word_t d;
      int cyc;
      int ar0;
      ar0 = ar_count;
      cpu_read(32'h48, d, cyc);
      compare_word("miss read", ref_mem[32'h48 >> 2], d);
      compare_count("miss burst count", ar0 + 1, ar_count);
      compare_addr("burst address", 32'h40, last_ar_addr);  // line aligned
      compare_count("burst length", 4 - 1, int'(last_ar_len));  // four-word line
      for (int w = 0; w < 4; w++)
      begin
         cpu_read(32'h40 + 32'(w * 4), d, cyc);
         compare_word("hit read", ref_mem[16 + w], d);
         compare_count("hit latency", HIT_CYCLES, cyc);
      end
      compare_count("hit burst count", ar0 + 1, ar_count);
   endtask

   task automatic test_write_hit();
      cache_pkg::word_t d;
      cache_pkg::wr_entry_t ent;
      int cyc;
      int ar0;
      ar0 = ar_count;
      d = $urandom;
      cpu_write(32'h44, d, 4'b0110, cyc, ent);
      compare_count("write hit latency", HIT_CYCLES, cyc);
      compare_write("write hit memory", ent);
      cpu_read(32'h44, d, cyc);
      compare_word("merged read", ref_mem[32'h44 >> 2], d);
      compare_count("merged read latency", HIT_CYCLES, cyc);
      compare_count("merged read burst", ar0, ar_count);
   endtask

   task automatic test_write_miss();
      cache_pkg::word_t d;
      cache_pkg::wr_entry_t ent;
      int cyc;
      int ar0;
      ar0 = ar_count;
      cpu_write(32'h200, $urandom, 4'b1111, cyc, ent);
      compare_count("no allocate", ar0, ar_count);
      cpu_read(32'h200, d, cyc);  // refill must see the posted write
      compare_word("write miss read", ref_mem[32'h200 >> 2], d);
      compare_count("write miss burst", ar0 + 1, ar_count);
      compare_write("write miss memory", ent);
   endtask

   task automatic test_conflict();
      cache_pkg::word_t d;
      cache_pkg::addr_t a;
      int cyc;
      int ar0;
      for (int i = 0; i < 6; i++)
      begin
         a = (i % 2 == 0) ? 32'h108 : 32'h508;  // same index, other tag
         ar0 = ar_count;
         cpu_read(a, d, cyc);
         compare_word("conflict read", ref_mem[a[13:2]], d);
         compare_count("conflict burst", ar0 + 1, ar_count);
      end
   endtask

   task automatic test_back_pressure();
      cache_pkg::word_t d;
      cache_pkg::wr_entry_t ents [BUF_DEPTH+1];
      cache_pkg::addr_t a;
      int cyc;
      int wr0;
      int ar0;
      bit last_done;
      wr0 = wr_total;
      ar0 = ar_count;
      @(posedge clk);
      stall_writes <= 1'b1;
      for (int i = 0; i < BUF_DEPTH; i++)
      begin
         a = 32'h600 + 32'(i * 4);
         cpu_write(a, $urandom, 4'b1111, cyc, ents[i]);
         compare_count("buffered write latency", HIT_CYCLES, cyc);
      end
      last_done = 1'b0;
      fork
         begin
            cpu_write(32'h60c, $urandom, 4'b1111, cyc, ents[BUF_DEPTH]);
            last_done = 1'b1;
         end
         begin
            repeat (20) @(posedge clk);
            if (last_done)
               stop_run("write accepted while the buffer was full");
            compare_count("stalled memory writes", wr0, wr_total);
            stall_writes <= 1'b0;
         end
      join
      cpu_read(32'h60c, d, cyc);
      compare_word("read behind writes", ref_mem[32'h60c >> 2], d);
      compare_count("refill after drain", wr0 + BUF_DEPTH + 1, writes_at_ar);
      compare_count("drain burst", ar0 + 1, ar_count);
      for (int i = 0; i <= BUF_DEPTH; i++)
         compare_write("write order", ents[i]);
   endtask

   initial
   begin
      void'($urandom(32'hb26c_9916));
      cycle_count  = 0;
      ar_count     = 0;
      wr_total     = 0;
      writes_at_ar = 0;
      reset        = 1'b1;
      stall_writes = 1'b0;
      cpu_valid    = 1'b0;
      cpu_addr     = '0;
      cpu_wdata    = '0;
      cpu_wstrb    = '0;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         ref_mem[i]      = $urandom;
         mem_i.words[i] <= ref_mem[i];
      end
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      test_miss_then_hit();
      test_write_hit();
      test_write_miss();
      test_conflict();
      test_back_pressure();
      $display(">>> PASS");
      $finish;
   end
endmodule

`default_nettype wire

/* design/cache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl #(
   parameter int INDEX_W = 6,
   parameter int WSEL_W  = 2
) (
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     cpu_valid,
   input  cache_pkg::addr_t        cpu_addr,
   input  cache_pkg::word_t        cpu_wdata,
   input  cache_pkg::strb_t        cpu_wstrb,
   output logic                    cpu_ready,
   output cache_pkg::word_t        cpu_rdata,
   store_if.ctrl                   st,
   fill_if.ctrl                    fl,
   output logic                    wb_push,
   output cache_pkg::wr_entry_t    wb_entry,
   input  wire                     wb_full,
   input  wire                     wb_empty
);
   localparam int OFS_W = WSEL_W + 2;  // word select plus byte offset

   typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_COMPARE, S_DRAIN, S_REFILL, S_REPLY} state_t;
   state_t state;

   logic is_write;

   assign is_write = |cpu_wstrb;  // any strobe set means write

   //////////////////////////////////////////////////
   // address split, cpu holds the request steady
   //////////////////////////////////////////////////

   assign st.wsel       = cpu_addr[OFS_W-1:2];
   assign st.index      = cpu_addr[INDEX_W+OFS_W-1:OFS_W];
   assign st.lookup_tag = cpu_addr[cache_pkg::ADDR_W-1:INDEX_W+OFS_W];
   assign st.wdata      = cpu_wdata;
   assign st.wstrb      = cpu_wstrb;

   assign fl.line_addr = {cpu_addr[cache_pkg::ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
   assign fl.start     = (state == S_DRAIN) && wb_empty && !fl.busy;  // no posted write left

   // every write is posted, a hit also patches the stored word
   assign wb_push       = (state == S_COMPARE) && is_write && !wb_full;
   assign st.we         = wb_push && st.hit;
   assign wb_entry.addr = {cpu_addr[cache_pkg::ADDR_W-1:2], 2'b00};
   assign wb_entry.data = cpu_wdata;
   assign wb_entry.strb = cpu_wstrb;

   assign cpu_ready = (state == S_REPLY);  // single cycle by construction

   //////////////////////////////////////////////////
   // request FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= S_IDLE;
      else
      begin
         case (state)
            S_IDLE:    if (cpu_valid) state <= S_LOOKUP;
            S_LOOKUP:  state <= S_COMPARE;  // arrays read at this edge
            S_COMPARE:
            begin
               if (is_write)
               begin
                  if (!wb_full) state <= S_REPLY;  // else hold until a slot frees
               end
               else if (st.hit)
                  state <= S_REPLY;
               else
                  state <= S_DRAIN;  // read miss
            end
            S_DRAIN:   if (fl.start) state <= S_REFILL;
            S_REFILL:  if (fl.done) state <= S_LOOKUP;  // read the word again
            S_REPLY:   state <= S_IDLE;
            default:   state <= S_IDLE;
         endcase
      end
   end

   // read data captured on a hit
   always_ff @(posedge clk)
   begin
      if (state == S_COMPARE && !is_write && st.hit)
         cpu_rdata <= st.rdata;
   end
endmodule

`default_nettype wire

/* design/cache_pkg.sv */
`default_nettype none

package cache_pkg;

   //////////////////////////////////////////////////
   // bus widths
   //////////////////////////////////////////////////

   localparam int ADDR_W = 32;  // byte address
   localparam int DATA_W = 32;  // one word
   localparam int STRB_W = DATA_W / 8;  // byte lanes per word

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] word_t;
   typedef logic [STRB_W-1:0] strb_t;

   //////////////////////////////////////////////////
   // posted write, as held in the write buffer
   //////////////////////////////////////////////////

   typedef struct packed
   {
      addr_t addr;  // word aligned
      word_t data;
      strb_t strb;  // nonzero for a real write
   } wr_entry_t;

endpackage

`default_nettype wire

/* design/fill_if.sv */
`timescale 1ns/1ns
`default_nettype none

// refill handshake between control and burst engine
interface fill_if;
   logic              start;      // one cycle, engine must be idle
   cache_pkg::addr_t  line_addr;  // line aligned
   logic              busy;
   logic              done;       // one cycle pulse after last beat written

   modport ctrl (
      output start,
      output line_addr,
      input  busy,
      input  done
   );

   modport fill (
      input  start,
      input  line_addr,
      output busy,
      output done
   );
endinterface

`default_nettype wire

/* design/line_fill.sv */
`timescale 1ns/1ns
`default_nettype none

module line_fill #(
   parameter int INDEX_W = 6,
   parameter int WSEL_W  = 2
) (
   input  wire               clk,
   input  wire               reset,
   fill_if.fill              fl,
   store_if.fill             st,
   output cache_pkg::addr_t  ar_addr,
   output logic [7:0]        ar_len,
   output logic              ar_valid,
   input  wire               ar_ready,
   input  cache_pkg::word_t  r_data,
   input  wire               r_valid,
   input  wire               r_last,
   output logic              r_ready
);
   localparam int OFS_W = WSEL_W + 2;
   localparam logic [7:0] BURST_LEN = 8'(2 ** WSEL_W - 1);  // beats minus one

   typedef enum logic [1:0] {F_IDLE, F_ADDR, F_DATA} fstate_t;
   fstate_t            state;
   cache_pkg::addr_t   line_q;
   logic [WSEL_W-1:0]  beat;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= F_IDLE;
         beat    <= '0;
         fl.done <= 1'b0;
      end
      else
      begin
         fl.done <= 1'b0;
         case (state)
            F_IDLE:
            begin
               beat <= '0;
               if (fl.start) state <= F_ADDR;
            end
            F_ADDR: if (ar_ready) state <= F_DATA;
            F_DATA:
            begin
               if (r_valid)
               begin
                  beat <= beat + 1'b1;
                  if (r_last)
                  begin
                     state   <= F_IDLE;
                     fl.done <= 1'b1;
                  end
               end
            end
            default: state <= F_IDLE;
         endcase
      end
   end

   // line address kept for the whole burst
   always_ff @(posedge clk)
   begin
      if (state == F_IDLE && fl.start)
         line_q <= fl.line_addr;
   end

   assign ar_valid = (state == F_ADDR);
   assign ar_addr  = line_q;
   assign ar_len   = BURST_LEN;
   assign r_ready  = 1'b1;  // store always takes a beat
   assign fl.busy  = (state != F_IDLE);

   // each beat goes straight into the line
   assign st.fill_we     = (state == F_DATA) && r_valid;
   assign st.fill_index  = line_q[INDEX_W+OFS_W-1:OFS_W];
   assign st.fill_wsel   = beat;
   assign st.fill_data   = r_data;
   assign st.fill_tag    = line_q[cache_pkg::ADDR_W-1:INDEX_W+OFS_W];
   assign st.fill_tag_we = st.fill_we && r_last;  // line complete
endmodule

`default_nettype wire

/* design/line_store.sv */
`timescale 1ns/1ns
`default_nettype none

module line_store #(
   parameter int INDEX_W = 6,
   parameter int WSEL_W  = 2
) (
   input  wire     clk,
   input  wire     reset,
   store_if.store  st
);
   localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - WSEL_W - 2;
   localparam int LINES = 2 ** INDEX_W;
   localparam int WORDS = LINES * (2 ** WSEL_W);

   logic [LINES-1:0]   valid_arr;
   logic [TAG_W-1:0]   tag_arr [LINES];
   cache_pkg::word_t   data_arr [WORDS];

   //////////////////////////////////////////////////
   // tag and valid
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
         valid_arr <= '0;  // whole cache invalid
      else if (st.fill_tag_we)
         valid_arr[st.fill_index] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (st.fill_tag_we)
         tag_arr[st.fill_index] <= st.fill_tag;
   end

   // hit flag for the lookup presented this cycle
   always_ff @(posedge clk)
   begin
      if (reset)
         st.hit <= 1'b0;
      else
         st.hit <= valid_arr[st.index] && (tag_arr[st.index] == st.lookup_tag);
   end

   //////////////////////////////////////////////////
   // data words
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (st.fill_we)
         data_arr[{st.fill_index, st.fill_wsel}] <= st.fill_data;  // full word
      else if (st.we)
      begin
         for (int b = 0; b < cache_pkg::STRB_W; b++)
         begin
            if (st.wstrb[b])  // only enabled bytes
               data_arr[{st.index, st.wsel}][b*8 +: 8] <= st.wdata[b*8 +: 8];
         end
      end
      st.rdata <= data_arr[{st.index, st.wsel}];
   end
endmodule

`default_nettype wire

/* design/memory_cache.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_cache #(
   parameter int INDEX_W   = 6,
   parameter int WSEL_W    = 2,  // 4-word lines
   parameter int BUF_DEPTH = 4
) (
   input  wire               clk,
   input  wire               reset,
   // cpu request port
   input  wire               cpu_valid,
   input  cache_pkg::addr_t  cpu_addr,
   input  cache_pkg::word_t  cpu_wdata,
   input  cache_pkg::strb_t  cpu_wstrb,
   output logic              cpu_ready,
   output cache_pkg::word_t  cpu_rdata,
   // memory read channels
   output cache_pkg::addr_t  ar_addr,
   output logic [7:0]        ar_len,
   output logic              ar_valid,
   input  wire               ar_ready,
   input  cache_pkg::word_t  r_data,
   input  wire               r_valid,
   input  wire               r_last,
   output logic              r_ready,
   // memory write channels
   output cache_pkg::addr_t  aw_addr,
   output cache_pkg::word_t  w_data,
   output cache_pkg::strb_t  w_strb,
   output logic              aw_valid,
   input  wire               aw_ready,
   input  wire               b_valid,
   output logic              b_ready
);
   logic                  wb_push;
   cache_pkg::wr_entry_t  wb_entry;
   logic                  wb_full;
   logic                  wb_empty;

   store_if #(.INDEX_W(INDEX_W), .WSEL_W(WSEL_W)) st_bus ();
   fill_if fl_bus ();

   //////////////////////////////////////////////////
   // control, arrays, refill and write path
   //////////////////////////////////////////////////

   cache_ctrl #(.INDEX_W(INDEX_W), .WSEL_W(WSEL_W)) u_ctrl (
      .clk(clk), .reset(reset),
      .cpu_valid(cpu_valid), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
      .cpu_wstrb(cpu_wstrb), .cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata),
      .st(st_bus.ctrl), .fl(fl_bus.ctrl),
      .wb_push(wb_push), .wb_entry(wb_entry), .wb_full(wb_full), .wb_empty(wb_empty)
   );

   line_store #(.INDEX_W(INDEX_W), .WSEL_W(WSEL_W)) u_store (
      .clk(clk), .reset(reset), .st(st_bus.store)
   );

   line_fill #(.INDEX_W(INDEX_W), .WSEL_W(WSEL_W)) u_fill (
      .clk(clk), .reset(reset), .fl(fl_bus.fill), .st(st_bus.fill),
      .ar_addr(ar_addr), .ar_len(ar_len), .ar_valid(ar_valid), .ar_ready(ar_ready),
      .r_data(r_data), .r_valid(r_valid), .r_last(r_last), .r_ready(r_ready)
   );

   write_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_wbuf (
      .clk(clk), .reset(reset),
      .push(wb_push), .entry(wb_entry), .full(wb_full), .empty(wb_empty),
      .aw_addr(aw_addr), .w_data(w_data), .w_strb(w_strb),
      .aw_valid(aw_valid), .aw_ready(aw_ready),
      .b_valid(b_valid), .b_ready(b_ready)
   );
endmodule

`default_nettype wire

/* design/store_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface store_if #(
   parameter int INDEX_W = 6,
   parameter int WSEL_W  = 2
);
   localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - WSEL_W - 2;

   // lookup and word write, from the control
   logic [INDEX_W-1:0] index;
   logic [WSEL_W-1:0]  wsel;
   cache_pkg::word_t   wdata;
   cache_pkg::strb_t   wstrb;
   logic               we;
   logic [TAG_W-1:0]   lookup_tag;
   // store answers one edge later
   cache_pkg::word_t   rdata;
   logic               hit;
   // refill path, wins over the control write
   logic               fill_we;
   logic [INDEX_W-1:0] fill_index;
   logic [WSEL_W-1:0]  fill_wsel;
   cache_pkg::word_t   fill_data;
   logic [TAG_W-1:0]   fill_tag;
   logic               fill_tag_we;  // sets tag and valid bit

   modport ctrl (output index, wsel, wdata, wstrb, we, lookup_tag, input rdata, hit);
   modport fill (output fill_we, fill_index, fill_wsel, fill_data, fill_tag, fill_tag_we);
   modport store (input index, wsel, wdata, wstrb, we, lookup_tag,
                  input fill_we, fill_index, fill_wsel, fill_data, fill_tag, fill_tag_we,
                  output rdata, hit);
endinterface

`default_nettype wire

/* design/write_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module write_buffer #(
   parameter int BUF_DEPTH = 4
) (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   push,
   input  cache_pkg::wr_entry_t  entry,
   output logic                  full,
   output logic                  empty,
   output cache_pkg::addr_t      aw_addr,
   output cache_pkg::word_t      w_data,
   output cache_pkg::strb_t      w_strb,
   output logic                  aw_valid,
   input  wire                   aw_ready,
   input  wire                   b_valid,
   output logic                  b_ready
);
   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   typedef enum logic {D_SEND, D_RESP} dstate_t;

   cache_pkg::wr_entry_t  mem [BUF_DEPTH];
   cache_pkg::wr_entry_t  head;
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [CNT_W-1:0]      count;
   dstate_t               state;
   logic                  pop;

   assign full  = (count == CNT_W'(BUF_DEPTH));
   assign empty = (count == '0);
   assign pop   = (state == D_RESP) && b_valid;  // entry leaves on its response

   //////////////////////////////////////////////////
   // circular queue
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= entry;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // drain, one write in flight
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= D_SEND;
      else if (state == D_SEND && aw_valid && aw_ready)
         state <= D_RESP;
      else if (pop)
         state <= D_SEND;
   end

   assign head     = mem[rd_ptr];  // stable until popped
   assign aw_valid = (state == D_SEND) && !empty;
   assign aw_addr  = head.addr;
   assign w_data   = head.data;
   assign w_strb   = head.strb;
   assign b_ready  = (state == D_RESP);
endmodule

`default_nettype wire

/* memory_cache.f */
design/cache_pkg.sv
design/store_if.sv
design/fill_if.sv
design/cache_ctrl.sv
design/line_store.sv
design/line_fill.sv
design/write_buffer.sv
design/memory_cache.sv
bench/mem_model.sv
bench/memory_cache_assert.sv
bench/memory_cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module memory_cache_tb \
   -f memory_cache.f \
   -o sim_memory_cache

./obj_dir/sim_memory_cache
